// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --timescale 1ns/1ps
TOP      := tbCore
FILELIST := compile.f

BUILDDIR := obj_dir
BIN      := $(BUILDDIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST)) source/coreConfig.svh

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)

// File: compile.f
+incdir+source
source/isaPkg.sv
source/corePkg.sv
source/decoder.sv
source/immGen.sv
source/regFile.sv
source/alu.sv
source/loadUnit.sv
source/pcUnit.sv
source/coreTop.sv
verification/tbCore.sv

// File: source/alu.sv
`timescale 1ns/1ps
`include "coreConfig.svh"

module alu (
	input  logic [`XLEN-1:0] opA,
	input  logic [`XLEN-1:0] opB,
	input  corePkg::aluOpT   op,
	output logic [`XLEN-1:0] result,
	output logic             zero
);
	import corePkg::*;

	logic [4:0] shamt;

	assign shamt = opB[4:0];

	always_comb begin
		case (op)
			aluAdd:   result = opA + opB;
			aluSub:   result = opA - opB;
			aluSll:   result = opA << shamt;
			aluSlt:   result = {{(`XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
			aluSltu:  result = {{(`XLEN-1){1'b0}}, opA < opB};
			aluXor:   result = opA ^ opB;
			aluSrl:   result = opA >> shamt;
			aluSra:   result = $unsigned($signed(opA) >>> shamt);
			aluOr:    result = opA | opB;
			aluAnd:   result = opA & opB;
			aluPassB: result = opB;
			default:  result = '0;
		endcase
	end

	assign zero = (result == '0); // beq compares via sub

endmodule

// File: source/coreConfig.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// word width for data and addresses
`define XLEN 32

// x0 included
`define REG_COUNT 32

`define RESET_PC 32'h8000_0000

`endif

// File: source/corePkg.sv
package corePkg;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluSll,
		aluSlt,
		aluSltu,
		aluXor,
		aluSrl,
		aluSra,
		aluOr,
		aluAnd,
		aluPassB // lui
	} aluOpT;

	typedef enum logic [1:0] {
		wbAlu,
		wbLoad,
		wbPcPlus4,
		wbBranch // pc + imm, auipc
	} wbSelT;

	typedef enum logic [1:0] {
		pcSeq,
		pcBranch,
		pcJalr
	} pcSelT;

	// matches funct3[1:0] of loads and stores
	typedef enum logic [1:0] {
		sizeByte = 2'b00,
		sizeHalf = 2'b01,
		sizeWord = 2'b10
	} accessSizeT;

	typedef struct packed {
		aluOpT      aluOp;
		logic       useImm;
		logic       regWrite;
		logic       memWrite;
		logic       memRead;
		wbSelT      wbSel;
		accessSizeT accessSize;
		logic       loadSigned;
		logic       isBranch;
		logic       isJal;
		logic       isJalr;
		logic       invalid;
		logic       ebreak;
	} ctrlT;

endpackage

// File: source/coreTop.sv
`timescale 1ns/1ps
`include "coreConfig.svh"

module coreTop (
	input  logic               clk,
	input  logic               arstN,
	input  logic [`XLEN-1:0]   inst,
	input  logic [`XLEN-1:0]   readData,
	output logic [`XLEN-1:0]   pc,
	output logic [`XLEN-1:0]   dataAddr,
	output logic [`XLEN-1:0]   storeData,
	output corePkg::accessSizeT accessSize,
	output logic               memWrite,
	output logic               memRead,
	output logic               invalid,
	output logic               halt
);
	import isaPkg::*;
	import corePkg::*;

	instrT            instWord;
	ctrlT             ctrl;
	logic [`XLEN-1:0] imm;
	logic [`XLEN-1:0] rs1Data;
	logic [`XLEN-1:0] rs2Data;
	logic [`XLEN-1:0] opB;
	logic [`XLEN-1:0] aluResult;
	logic             zero;
	logic [`XLEN-1:0] loadValue;
	logic [`XLEN-1:0] pcPlus4;
	logic [`XLEN-1:0] branchTarget;
	logic [`XLEN-1:0] rdData;

	assign instWord = inst;

	decoder decoder0 (.inst(instWord), .ctrl(ctrl));

	immGen immGen0 (.inst(instWord), .imm(imm));

	regFile regFile0 (
		.clk        (clk),
		.arstN      (arstN),
		.rs1Addr    (instWord.r.rs1),
		.rs2Addr    (instWord.r.rs2),
		.rdAddr     (instWord.r.rd),
		.rdData     (rdData),
		.writeEnable(ctrl.regWrite & ~ctrl.invalid),
		.rs1Data    (rs1Data),
		.rs2Data    (rs2Data)
	);

	assign opB = ctrl.useImm ? imm : rs2Data;

	alu alu0 (.opA(rs1Data), .opB(opB), .op(ctrl.aluOp), .result(aluResult), .zero(zero));

	loadUnit loadUnit0 (
		.raw       (readData),
		.size      (ctrl.accessSize),
		.signedLoad(ctrl.loadSigned),
		.value     (loadValue)
	);

	pcUnit pcUnit0 (
		.clk         (clk),
		.arstN       (arstN),
		.imm         (imm),
		.aluResult   (aluResult),
		.isBranch    (ctrl.isBranch),
		.isJal       (ctrl.isJal),
		.isJalr      (ctrl.isJalr),
		.zero        (zero),
		.pc          (pc),
		.pcPlus4     (pcPlus4),
		.branchTarget(branchTarget)
	);

	always_comb begin
		case (ctrl.wbSel)
			wbLoad:    rdData = loadValue;
			wbPcPlus4: rdData = pcPlus4; // link
			wbBranch:  rdData = branchTarget;
			default:   rdData = aluResult;
		endcase
	end

	assign dataAddr = aluResult;
	assign storeData = rs2Data; // lanes are left to memory
	assign accessSize = ctrl.accessSize;
	assign memWrite = ctrl.memWrite & ~ctrl.invalid;
	assign memRead = ctrl.memRead;
	assign invalid = ctrl.invalid;
	assign halt = ctrl.ebreak;

endmodule

// File: source/decoder.sv
`timescale 1ns/1ps

module decoder (
	input  isaPkg::instrT inst,
	output corePkg::ctrlT ctrl
);
	import isaPkg::*;
	import corePkg::*;

	function automatic aluOpT aluOpFor(input logic [2:0] f3, input logic alt);
		case (f3)
			f3Add:   return alt ? aluSub : aluAdd;
			f3Sll:   return aluSll;
			f3Slt:   return aluSlt;
			f3Sltu:  return aluSltu;
			f3Xor:   return aluXor;
			f3Sr:    return alt ? aluSra : aluSrl;
			f3Or:    return aluOr;
			default: return aluAnd;
		endcase
	endfunction

	always_comb begin
		ctrl = '0;
		ctrl.invalid = 1'b1; // cleared only by a supported encoding
		case (inst.r.opcode)
			opLui: begin
				ctrl.invalid = 1'b0;
				ctrl.aluOp = aluPassB;
				ctrl.useImm = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			opAuipc: begin
				ctrl.invalid = 1'b0;
				ctrl.regWrite = 1'b1;
				ctrl.wbSel = wbBranch;
			end
			opJal: begin
				ctrl.invalid = 1'b0;
				ctrl.regWrite = 1'b1;
				ctrl.wbSel = wbPcPlus4;
				ctrl.isJal = 1'b1;
			end
			opJalr: if (inst.i.funct3 == 3'b000) begin
				ctrl.invalid = 1'b0;
				ctrl.useImm = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.wbSel = wbPcPlus4;
				ctrl.isJalr = 1'b1;
			end
			opBranch: if (inst.b.funct3 == 3'b000) begin // beq only
				ctrl.invalid = 1'b0;
				ctrl.aluOp = aluSub;
				ctrl.isBranch = 1'b1;
			end
			opLoad: case (inst.i.funct3)
				memByte, memHalf, memWord, memByteU, memHalfU: begin
					ctrl.invalid = 1'b0;
					ctrl.useImm = 1'b1;
					ctrl.regWrite = 1'b1;
					ctrl.memRead = 1'b1;
					ctrl.wbSel = wbLoad;
					ctrl.accessSize = accessSizeT'(inst.i.funct3[1:0]);
					ctrl.loadSigned = ~inst.i.funct3[2];
				end
				default: ;
			endcase
			opStore: case (inst.s.funct3)
				memByte, memHalf, memWord: begin
					ctrl.invalid = 1'b0;
					ctrl.useImm = 1'b1;
					ctrl.memWrite = 1'b1;
					ctrl.accessSize = accessSizeT'(inst.s.funct3[1:0]);
				end
				default: ;
			endcase
			opImm: if (inst.i.funct3 != f3Sll && inst.i.funct3 != f3Sr) begin // no shifts
				ctrl.invalid = 1'b0;
				ctrl.useImm = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = aluOpFor(inst.i.funct3, 1'b0);
			end
			opReg: if (inst.r.funct7 == 7'b0000000 || (inst.r.funct7 == 7'b0100000 &&
					(inst.r.funct3 == f3Add || inst.r.funct3 == f3Sr))) begin
				ctrl.invalid = 1'b0;
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = aluOpFor(inst.r.funct3, inst.r.funct7[5]);
			end
			opSystem: if (inst.raw == 32'h0010_0073) begin
				ctrl.invalid = 1'b0;
				ctrl.ebreak = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

// File: source/immGen.sv
`timescale 1ns/1ps
`include "coreConfig.svh"

module immGen (
	input  isaPkg::instrT     inst,
	output logic [`XLEN-1:0] imm
);
	import isaPkg::*;

	always_comb begin
		case (inst.r.opcode)
			opJalr, opLoad, opImm:
				imm = {{(`XLEN-12){inst.i.imm[11]}}, inst.i.imm};
			opStore:
				imm = {{(`XLEN-12){inst.s.immHi[6]}}, inst.s.immHi, inst.s.immLo};
			opBranch:
				imm = {{(`XLEN-12){inst.b.imm12}}, inst.b.imm11, inst.b.imm10to5,
					inst.b.imm4to1, 1'b0};
			opLui, opAuipc:
				imm = {inst.u.imm, 12'b0};
			opJal:
				imm = {{(`XLEN-20){inst.j.imm20}}, inst.j.imm19to12, inst.j.imm11,
					inst.j.imm10to1, 1'b0};
			default:
				imm = '0;
		endcase
	end

endmodule

// File: source/isaPkg.sv
package isaPkg;

	typedef enum logic [6:0] {
		opLui    = 7'b0110111,
		opAuipc  = 7'b0010111,
		opJal    = 7'b1101111,
		opJalr   = 7'b1100111,
		opBranch = 7'b1100011,
		opLoad   = 7'b0000011,
		opStore  = 7'b0100011,
		opImm    = 7'b0010011,
		opReg    = 7'b0110011,
		opSystem = 7'b1110011
	} opcodeT;

	// OP and OP-IMM
	typedef enum logic [2:0] {
		f3Add  = 3'b000,
		f3Sll  = 3'b001,
		f3Slt  = 3'b010,
		f3Sltu = 3'b011,
		f3Xor  = 3'b100,
		f3Sr   = 3'b101,
		f3Or   = 3'b110,
		f3And  = 3'b111
	} aluF3T;

	// loads and stores, bit 2 marks unsigned
	typedef enum logic [2:0] {
		memByte  = 3'b000,
		memHalf  = 3'b001,
		memWord  = 3'b010,
		memByteU = 3'b100,
		memHalfU = 3'b101
	} memF3T;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		opcodeT     opcode;
	} rTypeT;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		opcodeT      opcode;
	} iTypeT;

	typedef struct packed {
		logic [6:0] immHi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] immLo;
		opcodeT     opcode;
	} sTypeT;

	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10to5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4to1;
		logic       imm11;
		opcodeT     opcode;
	} bTypeT;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0]  rd;
		opcodeT      opcode;
	} uTypeT;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10to1;
		logic       imm11;
		logic [7:0] imm19to12;
		logic [4:0] rd;
		opcodeT     opcode;
	} jTypeT;

	typedef union packed {
		rTypeT       r;
		iTypeT       i;
		sTypeT       s;
		bTypeT       b;
		uTypeT       u;
		jTypeT       j;
		logic [31:0] raw;
	} instrT;

endpackage

// File: source/loadUnit.sv
`timescale 1ns/1ps
`include "coreConfig.svh"

module loadUnit (
	input  logic [`XLEN-1:0]   raw,
	input  corePkg::accessSizeT size,
	input  logic               signedLoad,
	output logic [`XLEN-1:0]   value
);
	import corePkg::*;

	logic byteSign;
	logic halfSign;

	// data arrives already in the low lanes
	assign byteSign = signedLoad & raw[7];
	assign halfSign = signedLoad & raw[15];

	always_comb begin
		case (size)
			sizeByte: value = {{(`XLEN-8){byteSign}}, raw[7:0]};
			sizeHalf: value = {{(`XLEN-16){halfSign}}, raw[15:0]};
			default:  value = raw;
		endcase
	end

endmodule

// File: source/pcUnit.sv
`timescale 1ns/1ps
`include "coreConfig.svh"

module pcUnit (
	input  logic             clk,
	input  logic             arstN,
	input  logic [`XLEN-1:0] imm,
	input  logic [`XLEN-1:0] aluResult,
	input  logic             isBranch,
	input  logic             isJal,
	input  logic             isJalr,
	input  logic             zero,
	output logic [`XLEN-1:0] pc,
	output logic [`XLEN-1:0] pcPlus4,
	output logic [`XLEN-1:0] branchTarget
);
	import corePkg::*;

	pcSelT            pcSel;
	logic [`XLEN-1:0] nextPc;

	assign pcPlus4 = pc + `XLEN'd4;
	assign branchTarget = pc + imm; // also jal and auipc

	always_comb begin
		if (isJalr) pcSel = pcJalr;
		else if (isJal || (isBranch && zero)) pcSel = pcBranch;
		else pcSel = pcSeq;
	end

	always_comb begin
		case (pcSel)
			pcBranch: nextPc = branchTarget;
			pcJalr:   nextPc = {aluResult[`XLEN-1:1], 1'b0};
			default:  nextPc = pcPlus4;
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) pc <= `RESET_PC;
		else pc <= nextPc;
	end

endmodule

// File: source/regFile.sv
`timescale 1ns/1ps
`include "coreConfig.svh"

module regFile (
	input  logic             clk,
	input  logic             arstN,
	input  logic [4:0]       rs1Addr,
	input  logic [4:0]       rs2Addr,
	input  logic [4:0]       rdAddr,
	input  logic [`XLEN-1:0] rdData,
	input  logic             writeEnable,
	output logic [`XLEN-1:0] rs1Data,
	output logic [`XLEN-1:0] rs2Data
);
	logic [`XLEN-1:0] regs [1:`REG_COUNT-1]; // x0 has no storage

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 1; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEnable && rdAddr != 5'd0) begin
			regs[rdAddr] <= rdData;
		end
	end

	assign rs1Data = (rs1Addr == 5'd0) ? '0 : regs[rs1Addr];
	assign rs2Data = (rs2Addr == 5'd0) ? '0 : regs[rs2Addr];

endmodule

// File: verification/tbCore.sv
`timescale 1ns/1ps
`include "coreConfig.svh"

module tbCore;
	import corePkg::*;

	localparam logic [6:0] opcLui = 7'b0110111;
	localparam logic [6:0] opcAuipc = 7'b0010111;
	localparam logic [6:0] opcJal = 7'b1101111;
	localparam logic [6:0] opcJalr = 7'b1100111;
	localparam logic [6:0] opcBranch = 7'b1100011;
	localparam logic [6:0] opcLoad = 7'b0000011;
	localparam logic [6:0] opcStore = 7'b0100011;
	localparam logic [6:0] opcImm = 7'b0010011;
	localparam logic [6:0] opcReg = 7'b0110011;
	localparam logic [31:0] nopWord = 32'h0000_0013;
	localparam logic [31:0] ebreakWord = 32'h0010_0073;
	localparam int instrCount = 400;

	// expected behaviour of one instruction
	typedef struct packed {
		logic [31:0] nextPc;
		logic [31:0] dataAddr;
		logic [31:0] storeData;
		logic [31:0] readData;
		logic [31:0] rdVal;
		logic [4:0]  rd;
		logic [1:0]  size;
		logic        memOp;
		logic        memRead;
		logic        memWrite;
		logic        regWrite;
		logic        invalid;
		logic        halt;
	} expT;

	logic             clk;
	logic             arstN;
	logic [31:0]      inst;
	logic [31:0]      readData;
	logic [31:0]      pc;
	logic [31:0]      dataAddr;
	logic [31:0]      storeData;
	accessSizeT       accessSize;
	logic             memWrite;
	logic             memRead;
	logic             invalid;
	logic             halt;

	logic [31:0] mPc;
	logic [31:0] mRegs [0:31];
	logic [31:0] mem [0:63]; // 256 byte data window
	logic [31:0] lcgState;
	logic [4:0]  pendingStore;
	expT         cur;
	logic        checking;
	logic        haltSeen;

	coreTop dut0 (
		.clk       (clk),
		.arstN     (arstN),
		.inst      (inst),
		.readData  (readData),
		.pc        (pc),
		.dataAddr  (dataAddr),
		.storeData (storeData),
		.accessSize(accessSize),
		.memWrite  (memWrite),
		.memRead   (memRead),
		.invalid   (invalid),
		.halt      (halt)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic logic [31:0] pick(input logic [31:0] n);
		return (nextRand() >> 8) % n; // low lcg bits are weak
	endfunction

	function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [6:0] op);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], op};
	endfunction

	function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [6:0] op);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op};
	endfunction

	function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opcJal};
	endfunction

	function automatic logic [31:0] randomInstr();
		logic [31:0] w;
		logic [31:0] r;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [2:0]  f3;
		logic [11:0] off;
		logic        alt;
		rd = 5'(32'd1 + pick(7)); // x1 to x7 only
		rs1 = 5'(32'd1 + pick(7));
		rs2 = 5'(32'd1 + pick(7));
		r = nextRand();
		if (pendingStore != 5'd0) begin
			w = encS(12'(pick(64) * 4), pendingStore, 5'd0, 3'd2, opcStore);
			pendingStore = 5'd0;
			return w;
		end
		case (pick(10))
			0: begin
				f3 = r[18:16];
				alt = (f3 == 3'd0 || f3 == 3'd5) && r[20];
				w = {alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd, opcReg};
			end
			1: begin
				f3 = 3'(pick(8));
				if (f3 == 3'd1 || f3 == 3'd5) f3 = f3 + 3'd1; // no shift immediates
				w = encI(r[31:20], rs1, f3, rd, opcImm);
			end
			2: w = {r[31:12], rd, opcLui};
			3: w = {r[31:12], rd, opcAuipc};
			4: begin
				f3 = 3'(pick(5));
				if (f3 == 3'd3) f3 = 3'd4;
				else if (f3 == 3'd4) f3 = 3'd5;
				off = 12'(pick(256)) & ~((12'd1 << f3[1:0]) - 12'd1);
				w = encI(off, 5'd0, f3, rd, opcLoad);
			end
			5: begin
				f3 = 3'(pick(3));
				off = 12'(pick(256)) & ~((12'd1 << f3[1:0]) - 12'd1);
				w = encS(off, rs2, 5'd0, f3, opcStore);
			end
			6: w = encB({r[27:16], 1'b0}, r[8] ? rs1 : rs2, rs1, 3'd0, opcBranch);
			7: w = encJ({r[29:10], 1'b0}, rd);
			8: w = encI(r[23:12], rs1, 3'd0, rd, opcJalr); // odd targets too
			default: begin
				case (pick(4))
					0: w = encB(13'd8, rs2, rs1, 3'd1, opcBranch); // bne
					1: w = encI(r[31:20], rs1, 3'd0, rd, 7'b0001111);
					2: w = encS(12'h010, rs2, 5'd0, 3'd3, opcStore); // sd
					default: w = encI(12'd3, rs1, 3'd1, rd, opcImm);
				endcase
			end
		endcase
		if (w[6:0] != opcStore && w[6:0] != opcBranch) pendingStore = rd;
		return w;
	endfunction

	function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic [31:0] x,
			input logic [31:0] y, input logic alt);
		logic signed [31:0] sx;
		logic signed [31:0] sy;
		sx = x;
		sy = y;
		case (f3)
			3'd0: return alt ? x - y : x + y;
			3'd1: return x << y[4:0];
			3'd2: return {31'b0, sx < sy};
			3'd3: return {31'b0, x < y};
			3'd4: return x ^ y;
			3'd5: begin
				if (alt) return sx >>> y[4:0];
				else return x >> y[4:0];
			end
			3'd6: return x | y;
			default: return x & y;
		endcase
	endfunction

	// executes one instruction on the model state without committing it
	function automatic expT refStep(input logic [31:0] w);
		expT         e;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] immI;
		logic [31:0] immS;
		logic [31:0] immB;
		logic [31:0] immU;
		logic [31:0] immJ;
		logic [31:0] word;
		e = '0;
		f3 = w[14:12];
		f7 = w[31:25];
		a = mRegs[w[19:15]];
		b = mRegs[w[24:20]];
		immI = {{20{w[31]}}, w[31:20]};
		immS = {{20{w[31]}}, w[31:25], w[11:7]};
		immB = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
		immU = {w[31:12], 12'b0};
		immJ = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
		e.invalid = 1'b1;
		e.nextPc = mPc + 32'd4;
		e.storeData = b;
		e.rd = w[11:7];
		case (w[6:0])
			opcLui: {e.invalid, e.regWrite, e.rdVal} = {2'b01, immU};
			opcAuipc: {e.invalid, e.regWrite, e.rdVal} = {2'b01, mPc + immU};
			opcJal: begin
				{e.invalid, e.regWrite, e.rdVal} = {2'b01, mPc + 32'd4};
				e.nextPc = mPc + immJ;
			end
			opcJalr: if (f3 == 3'd0) begin
				{e.invalid, e.regWrite, e.rdVal} = {2'b01, mPc + 32'd4};
				e.nextPc = (a + immI) & ~32'd1;
			end
			opcBranch: if (f3 == 3'd0) begin
				e.invalid = 1'b0;
				if (a == b) e.nextPc = mPc + immB;
			end
			opcLoad: if (f3 != 3'd3 && f3 < 3'd6) begin
				{e.invalid, e.regWrite, e.memOp, e.memRead} = 4'b0111;
				e.dataAddr = a + immI;
				e.size = f3[1:0];
				word = mem[e.dataAddr[7:2]] >> {e.dataAddr[1:0], 3'b000}; // lanes moved down
				e.readData = word;
				case (f3[1:0])
					2'd0: e.rdVal = f3[2] ? {24'b0, word[7:0]} : {{24{word[7]}}, word[7:0]};
					2'd1: e.rdVal = f3[2] ? {16'b0, word[15:0]} : {{16{word[15]}}, word[15:0]};
					default: e.rdVal = word;
				endcase
			end
			opcStore: if (f3 < 3'd3) begin
				{e.invalid, e.memOp, e.memWrite} = 3'b011;
				e.dataAddr = a + immS;
				e.size = f3[1:0];
			end
			opcImm: if (f3 != 3'd1 && f3 != 3'd5) begin
				{e.invalid, e.regWrite, e.rdVal} = {2'b01, aluRef(f3, a, immI, 1'b0)};
			end
			opcReg: if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) begin
				{e.invalid, e.regWrite, e.rdVal} = {2'b01, aluRef(f3, a, b, f7[5])};
			end
			default: if (w == ebreakWord) {e.invalid, e.halt} = 2'b01;
		endcase
		return e;
	endfunction

	function automatic void commitModel(input expT e);
		logic [5:0] idx;
		logic [4:0] lane;
		idx = e.dataAddr[7:2];
		lane = {e.dataAddr[1:0], 3'b000};
		if (e.regWrite && e.rd != 5'd0) mRegs[e.rd] = e.rdVal;
		if (e.memWrite) begin
			case (e.size)
				2'd0: mem[idx][lane +: 8] = e.storeData[7:0];
				2'd1: mem[idx][lane +: 16] = e.storeData[15:0];
				default: mem[idx] = e.storeData;
			endcase
		end
		mPc = e.nextPc;
	endfunction

	task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] want);
		if (got !== want) begin
			$display("ERROR at %0t: %s is %h, expected %h", $time, name, got, want);
			$display("Verification failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("Verification failed");
		$fatal(1, "run aborted");
	endtask

	always @(negedge clk) begin
		if (!arstN) begin
			checkEq("pc in reset", pc, `RESET_PC);
		end else if (checking) begin
			checkEq("pc", pc, mPc);
			checkEq("invalid", 32'(invalid), 32'(cur.invalid));
			checkEq("memWrite", 32'(memWrite), 32'(cur.memWrite));
			checkEq("memRead", 32'(memRead), 32'(cur.memRead));
			checkEq("storeData", storeData, cur.storeData);
			checkEq("halt", 32'(halt), 32'(cur.halt));
			if (cur.memOp) begin
				checkEq("dataAddr", dataAddr, cur.dataAddr);
				checkEq("accessSize", 32'(accessSize), 32'(cur.size));
			end
			if (halt === 1'b1) haltSeen = 1'b1;
		end
	end

	initial begin
		logic [31:0] next;
		int          waited;
		int          issued;
		int          cycles;
		logic        finished;
		arstN <= 1'b0;
		inst <= nopWord;
		readData <= '0;
		checking = 1'b0;
		haltSeen = 1'b0;
		lcgState = 32'd61;
		pendingStore = 5'd0;
		mPc = `RESET_PC;
		for (int i = 0; i < 32; i++) mRegs[i] = '0;
		for (int i = 0; i < 64; i++) mem[i] = (32'(i) * 32'h9E37_79B9) ^ {8'(i), 24'h5AC3E1};

		waited = 0;
		while (pc !== `RESET_PC) begin
			@(negedge clk);
			waited++;
			if (waited > 8) abortRun("pc did not take the reset value while reset was held");
		end
		repeat (2) @(posedge clk); // third edge in reset

		@(posedge clk);
		arstN <= 1'b1;
		next = encI(12'h040, 5'd0, 3'd2, 5'd1, opcLoad); // lw x1, 0x40(x0)
		pendingStore = 5'd1;
		cur = refStep(next);
		inst <= next;
		readData <= cur.readData;
		checking = 1'b1;

		issued = 0;
		cycles = 0;
		finished = 1'b0;
		while (!finished) begin
			@(posedge clk);
			if (haltSeen) begin
				finished = 1'b1;
			end else begin
				cycles++;
				if (cycles > instrCount + 16) abortRun("Timeout: halt never seen after ebreak");
				commitModel(cur);
				next = (issued == instrCount) ? ebreakWord : randomInstr();
				issued++;
				cur = refStep(next);
				inst <= next;
				readData <= cur.readData;
			end
		end

		$display("Verification passed");
		$finish;
	end

endmodule
